/* source/isa_pkg.sv */
/*
 * RV32I instruction word views (R-type and I/B-type) and their union,
 * opcode constants, and the decode enumerations
 */
`default_nettype none

package isa_pkg;

	localparam int xlen       = 32;               // word width
	localparam int areg_width = 5;                // architectural reg index
	localparam logic [areg_width-1:0] zero_reg = '0;    // x0, no writeback

	////////////////////////////////////////
	// major opcodes
	////////////////////////////////////////
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_system = 7'b1110011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fields_t;

	typedef struct packed {
		logic [11:0] imm;                     // also funct7 + rs2 of an R-type
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} ib_fields_t;

	typedef union packed {
		r_fields_t  r;                        // register view
		ib_fields_t ib;                       // immediate view
	} inst_t;

	typedef enum logic [1:0] {fu_alu, fu_mult, fu_mem, fu_branch} fu_type_t;   // indexes rs_full

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra, alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
	} alu_func_t;

	typedef enum logic [1:0] {opa_is_rs1, opa_is_pc, opa_is_zero} opa_sel_t;
	typedef enum logic [1:0] {opb_is_rs2, opb_is_i_imm, opb_is_s_imm, opb_is_u_imm} opb_sel_t;

endpackage

`default_nettype wire

/* source/frontend_pkg.sv */
/*
 * Front-end sizes and table depths, plus the resolved-branch,
 * prediction and issue-packet structs
 */
`default_nettype none

package frontend_pkg;

	import isa_pkg::*;

	localparam int btb_entries   = 16;        // direct mapped
	localparam int pht_entries   = 64;        // per direction table
	localparam int ghr_width     = 6;         // matches pht index
	localparam int btb_idx_width = $clog2(btb_entries);
	localparam int pht_idx_width = $clog2(pht_entries);
	localparam int btb_tag_width = xlen - btb_idx_width - 2;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;                  // pc of the resolved branch
		logic [xlen-1:0] target_pc;           // where it actually went
		logic            cond_branch;
		logic            uncond_branch;
		logic            taken;
		logic            local_taken;         // predictions stored at fetch
		logic            global_taken;
		logic            mis_pred;
	} result_t;

	typedef struct packed {
		logic            local_taken;
		logic            global_taken;
		logic            tournament_taken;
		logic            btb_hit;
		logic [xlen-1:0] btb_target;
	} pred_t;

	typedef struct packed {
		logic                  valid;
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       npc;
		inst_t                 inst;
		logic [areg_width-1:0] opa_areg_idx;
		logic [areg_width-1:0] opb_areg_idx;
		logic [areg_width-1:0] dest_areg_idx;
		opa_sel_t              opa_select;
		opb_sel_t              opb_select;
		alu_func_t             alu_func;
		fu_type_t              fu_type;
		logic                  rd_mem;
		logic                  wr_mem;
		logic                  cond_branch;
		logic                  uncond_branch;
		logic                  csr_op;
		logic                  halt;
		logic                  illegal;
		logic                  branch_prediction;
		logic                  local_taken;
		logic                  global_taken;
	} id_packet_t;

endpackage

`default_nettype wire

/* source/inst_decoder.sv */
/*
 * Combinational RV32I(M) decode into unit class, ALU op, operand
 * selects, memory and branch kind, and destination use
 */
`default_nettype none
`timescale 1ns/1ps

module inst_decoder (
	input  isa_pkg::inst_t     inst,
	output isa_pkg::fu_type_t  fu_type,
	output isa_pkg::alu_func_t alu_func,
	output isa_pkg::opa_sel_t  opa_select,
	output isa_pkg::opb_sel_t  opb_select,
	output logic               dest_is_rd,
	output logic               rd_mem,
	output logic               wr_mem,
	output logic               cond_branch,
	output logic               uncond_branch,
	output logic               csr_op,
	output logic               halt,
	output logic               illegal
);
	import isa_pkg::*;

	// funct3 to alu op, alt picks sub / sra
	function automatic alu_func_t base_op(input logic [2:0] funct3, input logic alt);
		alu_func_t op;
		case (funct3)
			3'd0:    op = alt ? alu_sub : alu_add;
			3'd1:    op = alu_sll;
			3'd2:    op = alu_slt;
			3'd3:    op = alu_sltu;
			3'd4:    op = alu_xor;
			3'd5:    op = alt ? alu_sra : alu_srl;
			3'd6:    op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	always_comb begin
		fu_type       = fu_alu;             // safe defaults
		alu_func      = alu_add;
		opa_select    = opa_is_rs1;
		opb_select    = opb_is_rs2;
		dest_is_rd    = 1'b0;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		csr_op        = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		case (inst.ib.opcode)
			opc_op: begin
				dest_is_rd = 1'b1;
				if (inst.ib.imm[11:5] == 7'b0000001) begin   // M extension
					fu_type  = fu_mult;
					alu_func = alu_func_t'(alu_mul + {2'b00, inst.ib.funct3[1:0]});
					illegal  = inst.ib.funct3[2];                // no divide unit
				end else
					alu_func = base_op(inst.ib.funct3, inst.ib.imm[10]);
			end
			opc_op_imm: begin
				dest_is_rd = 1'b1;
				opb_select = opb_is_i_imm;
				alu_func   = base_op(inst.ib.funct3, inst.ib.funct3 == 3'd5 && inst.ib.imm[10]);
			end
			opc_load: begin
				fu_type    = fu_mem;
				rd_mem     = 1'b1;
				dest_is_rd = 1'b1;
				opb_select = opb_is_i_imm;
			end
			opc_store: begin
				fu_type    = fu_mem;
				wr_mem     = 1'b1;
				opb_select = opb_is_s_imm;
			end
			opc_branch: begin
				fu_type     = fu_branch;
				cond_branch = 1'b1;
				alu_func    = alu_sub;            // compare
			end
			opc_jal: begin
				fu_type       = fu_branch;
				uncond_branch = 1'b1;
				dest_is_rd    = 1'b1;
				opa_select    = opa_is_pc;
				opb_select    = opb_is_i_imm;
			end
			opc_jalr: begin
				fu_type       = fu_branch;
				uncond_branch = 1'b1;
				dest_is_rd    = 1'b1;
				opb_select    = opb_is_i_imm;
			end
			opc_lui: begin
				dest_is_rd = 1'b1;
				opa_select = opa_is_zero;
				opb_select = opb_is_u_imm;
			end
			opc_auipc: begin
				dest_is_rd = 1'b1;
				opa_select = opa_is_pc;
				opb_select = opb_is_u_imm;
			end
			opc_system: begin
				csr_op     = inst.ib.funct3 != 3'd0;           // csrrw and friends
				dest_is_rd = csr_op;
				halt       = inst.ib.funct3 == 3'd0 && inst.ib.imm == 12'h105;   // wfi
			end
			default:    illegal = 1'b1;             // alu, no writeback
		endcase
	end

endmodule

`default_nettype wire

/* source/branch_target_buffer.sv */
/*
 * Direct-mapped tagged branch target buffer
 */
`default_nettype none
`timescale 1ns/1ps

module branch_target_buffer (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [isa_pkg::xlen-1:0] pc,
	input  logic                     train,
	input  frontend_pkg::result_t    result,
	output logic                     btb_hit,
	output logic [isa_pkg::xlen-1:0] btb_target
);
	import isa_pkg::*;
	import frontend_pkg::*;

	logic [btb_entries-1:0]   entry_valid;
	logic [btb_tag_width-1:0] tag_mem    [btb_entries];
	logic [xlen-1:0]          target_mem [btb_entries];
	logic [btb_idx_width-1:0] rd_idx;
	logic [btb_idx_width-1:0] wr_idx;
	logic [btb_tag_width-1:0] rd_tag;
	logic [btb_tag_width-1:0] wr_tag;
	logic                     write_en;

	assign rd_idx   = pc[btb_idx_width+1:2];
	assign rd_tag   = pc[xlen-1:btb_idx_width+2];
	assign wr_idx   = result.pc[btb_idx_width+1:2];
	assign wr_tag   = result.pc[xlen-1:btb_idx_width+2];
	assign write_en = train & result.taken;          // only taken branches allocate

	assign btb_hit    = entry_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign btb_target = target_mem[rd_idx];

	always_ff @(posedge clock) begin
		if (reset)
			entry_valid <= '0;
		else if (write_en)
			entry_valid[wr_idx] <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (write_en) begin
			tag_mem[wr_idx]    <= wr_tag;
			target_mem[wr_idx] <= result.target_pc;
		end
	end

endmodule

`default_nettype wire

/* source/branch_predictor.sv */
/*
 * Tournament direction predictor: bimodal table, gshare table and
 * a chooser, read by fetch pc and trained by resolved branches
 */
`default_nettype none
`timescale 1ns/1ps

module branch_predictor (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [isa_pkg::xlen-1:0] pc,
	input  logic                     train,
	input  frontend_pkg::result_t    result,
	output logic                     local_taken,
	output logic                     global_taken,
	output logic                     tournament_taken
);
	import isa_pkg::*;
	import frontend_pkg::*;

	localparam logic [1:0] weak_nt = 2'b01;      // reset counter value

	logic [1:0]               local_pht  [pht_entries];
	logic [1:0]               global_pht [pht_entries];
	logic [1:0]               chooser    [pht_entries];   // msb set picks global
	logic [ghr_width-1:0]     ghr;                         // newest outcome in lsb
	logic [pht_idx_width-1:0] rd_local_idx;
	logic [pht_idx_width-1:0] rd_global_idx;
	logic [pht_idx_width-1:0] wr_local_idx;
	logic [pht_idx_width-1:0] wr_global_idx;
	logic                     disagree;

	function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
		logic [1:0] nxt;
		nxt = cnt;
		if (up && cnt != 2'b11)
			nxt = cnt + 2'b01;
		else if (!up && cnt != 2'b00)
			nxt = cnt - 2'b01;
		return nxt;
	endfunction

	////////////////////////////////////////
	// lookup
	////////////////////////////////////////
	assign rd_local_idx  = pc[pht_idx_width+1:2];
	assign rd_global_idx = pc[pht_idx_width+1:2] ^ ghr;   // gshare hash

	assign local_taken      = local_pht[rd_local_idx][1];
	assign global_taken     = global_pht[rd_global_idx][1];
	assign tournament_taken = chooser[rd_local_idx][1] ? global_taken : local_taken;

	////////////////////////////////////////
	// training
	////////////////////////////////////////
	assign wr_local_idx  = result.pc[pht_idx_width+1:2];
	assign wr_global_idx = result.pc[pht_idx_width+1:2] ^ ghr;
	assign disagree      = result.local_taken ^ result.global_taken;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < pht_entries; i++) begin
				local_pht[i]  <= weak_nt;
				global_pht[i] <= weak_nt;
				chooser[i]    <= weak_nt;       // weakly local
			end
			ghr <= '0;
		end else if (train) begin
			local_pht[wr_local_idx]   <= sat_step(local_pht[wr_local_idx], result.taken);
			global_pht[wr_global_idx] <= sat_step(global_pht[wr_global_idx], result.taken);
			if (disagree)                     // lean toward whichever was right
				chooser[wr_local_idx] <= sat_step(chooser[wr_local_idx],
					result.global_taken == result.taken);
			ghr <= {ghr[ghr_width-2:0], result.taken};
		end
	end

endmodule

`default_nettype wire

/* source/fetch_control.sv */
/*
 * PC register with redirect / hold / advance, next-PC choice,
 * stall check and issue packet assembly, training strobes
 */
`default_nettype none
`timescale 1ns/1ps

module fetch_control (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     rob_full,
	input  logic [3:0]               rs_full,
	input  logic                     icache_valid,
	input  frontend_pkg::result_t    result,
	input  frontend_pkg::pred_t      pred,
	input  isa_pkg::fu_type_t        fu_type,
	input  isa_pkg::alu_func_t       alu_func,
	input  isa_pkg::opa_sel_t        opa_select,
	input  isa_pkg::opb_sel_t        opb_select,
	input  logic                     dest_is_rd,
	input  logic                     rd_mem,
	input  logic                     wr_mem,
	input  logic                     cond_branch,
	input  logic                     uncond_branch,
	input  logic                     csr_op,
	input  logic                     halt,
	input  logic                     illegal,
	input  isa_pkg::inst_t           icache_data,
	output logic [isa_pkg::xlen-1:0] pc,
	output logic [isa_pkg::xlen-1:0] icache_addr,
	output logic                     train_dir,
	output logic                     train_btb,
	output frontend_pkg::id_packet_t id_packet
);
	import isa_pkg::*;
	import frontend_pkg::*;

	logic            redirect;               // resolved mispredict
	logic            packet_valid;
	logic            take_btb;               // follow the btb target
	logic [xlen-1:0] npc;

	////////////////////////////////////////
	// resolved-branch strobes
	////////////////////////////////////////
	assign train_dir = result.valid & result.cond_branch & ~reset;
	assign train_btb = result.valid & (result.cond_branch | result.uncond_branch) & ~reset;
	assign redirect  = result.valid & result.mis_pred & ~reset;

	assign take_btb = pred.btb_hit & (uncond_branch | (cond_branch & pred.tournament_taken));
	assign npc      = take_btb ? pred.btb_target : pc + xlen'(4);

	// stall on rob or on the rs for this class
	assign packet_valid = icache_valid & ~redirect & ~rob_full & ~rs_full[fu_type];
	assign icache_addr  = {pc[xlen-1:2], 2'b00};   // word aligned

	always_ff @(posedge clock) begin
		if (reset)
			pc <= '0;
		else if (redirect)
			pc <= result.target_pc;           // mispredict wins
		else if (packet_valid)
			pc <= npc;                        // advance; otherwise hold and replay
	end

	always_comb begin
		id_packet                   = '0;
		id_packet.valid             = packet_valid;
		id_packet.pc                = pc;
		id_packet.npc               = npc;
		id_packet.inst              = icache_data;
		id_packet.opa_areg_idx      = icache_data.r.rs1;
		id_packet.opb_areg_idx      = icache_data.r.rs2;
		id_packet.dest_areg_idx     = dest_is_rd ? icache_data.r.rd : zero_reg;
		id_packet.opa_select        = opa_select;
		id_packet.opb_select        = opb_select;
		id_packet.alu_func          = alu_func;
		id_packet.fu_type           = fu_type;
		id_packet.rd_mem            = rd_mem;
		id_packet.wr_mem            = wr_mem;
		id_packet.cond_branch       = cond_branch;
		id_packet.uncond_branch     = uncond_branch;
		id_packet.csr_op            = csr_op;
		id_packet.halt              = halt;
		id_packet.illegal           = illegal;
		id_packet.branch_prediction = pred.btb_hit & pred.tournament_taken;
		id_packet.local_taken       = pred.local_taken;     // carried to resolve
		id_packet.global_taken      = pred.global_taken;
	end

endmodule

`default_nettype wire

/* source/fetch_decode_top.sv */
/*
 * Fetch/decode front end top: control, predictor, BTB and decoder
 */
`default_nettype none
`timescale 1ns/1ps

module fetch_decode_top (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     rob_full,
	input  logic [3:0]               rs_full,
	input  isa_pkg::inst_t           icache_data,
	input  logic                     icache_valid,
	input  frontend_pkg::result_t    result,
	output logic [isa_pkg::xlen-1:0] icache_addr,
	output frontend_pkg::id_packet_t id_packet
);
	import isa_pkg::*;
	import frontend_pkg::*;

	logic [xlen-1:0] pc;
	pred_t           pred;                   // predictor + btb halves
	logic            train_dir, train_btb;
	fu_type_t        fu_type;
	alu_func_t       alu_func;
	opa_sel_t        opa_select;
	opb_sel_t        opb_select;
	logic            dest_is_rd, rd_mem, wr_mem, cond_branch, uncond_branch;
	logic            csr_op, halt, illegal;

	fetch_control ctrl (.clock, .reset, .rob_full, .rs_full, .icache_valid, .result, .pred,
		.fu_type, .alu_func, .opa_select, .opb_select, .dest_is_rd, .rd_mem, .wr_mem,
		.cond_branch, .uncond_branch, .csr_op, .halt, .illegal, .icache_data,
		.pc, .icache_addr, .train_dir, .train_btb, .id_packet);

	branch_predictor bp (.clock, .reset, .pc, .train(train_dir), .result,
		.local_taken(pred.local_taken), .global_taken(pred.global_taken),
		.tournament_taken(pred.tournament_taken));

	branch_target_buffer btb (.clock, .reset, .pc, .train(train_btb), .result,
		.btb_hit(pred.btb_hit), .btb_target(pred.btb_target));

	inst_decoder dec (.inst(icache_data), .fu_type, .alu_func, .opa_select, .opb_select,
		.dest_is_rd, .rd_mem, .wr_mem, .cond_branch, .uncond_branch, .csr_op, .halt, .illegal);

endmodule

`default_nettype wire

/* dv/fetch_decode_assert.sv */
/*
 * Bound checker for the front-end top: reset PC, sequential fetch,
 * back-pressure hold, stalls, redirect, decode fields, trained prediction
 */
`default_nettype none
`timescale 1ns/1ps

module fetch_decode_assert (
	input logic                     clock,
	input logic                     reset,
	input logic                     rob_full,
	input logic [3:0]               rs_full,
	input logic [31:0]              icache_data,
	input logic                     icache_valid,
	input frontend_pkg::result_t    result,
	input logic [31:0]              icache_addr,
	input frontend_pkg::id_packet_t id_packet
);
	import isa_pkg::*;
	import frontend_pkg::*;

	int              error_count = 0;        // read by the testbench
	logic            redirect;
	logic [6:0]      opcode;
	logic [4:0]      exp_dest;
	fu_type_t        exp_fu;                 // class from the raw word
	logic            trained;                // one taken cond resolution so far
	logic            resolved_any;
	logic [xlen-1:0] trained_pc;
	logic [xlen-1:0] trained_target;

	assign redirect = result.valid & result.mis_pred;
	assign opcode   = icache_data[6:0];
	assign exp_dest = (opcode == opc_store || opcode == opc_branch) ? zero_reg : icache_data[11:7];

	always_comb begin
		case (opcode)
			opc_load, opc_store:           exp_fu = fu_mem;
			opc_branch, opc_jal, opc_jalr: exp_fu = fu_branch;
			opc_op:  exp_fu = (icache_data[31:25] == 7'b0000001) ? fu_mult : fu_alu;
			default: exp_fu = fu_alu;
		endcase
	end

	// tracks whether the tables hold exactly one taken outcome
	always_ff @(posedge clock) begin
		if (reset) begin
			trained      <= 1'b0;
			resolved_any <= 1'b0;
		end else if (result.valid) begin
			resolved_any   <= 1'b1;
			trained        <= !resolved_any && result.cond_branch && result.taken;
			trained_pc     <= result.pc;
			trained_target <= result.target_pc;
		end
	end

	////////////////////////////////////////
	// next-pc and stall rules
	////////////////////////////////////////
	assert property (@(posedge clock) $fell(reset) |-> icache_addr == '0)
		else begin
			error_count++;
			$error("ERR %0t: fetch address not 0 after reset", $time);
		end

	assert property (@(posedge clock) disable iff (reset)
		id_packet.valid && !id_packet.branch_prediction && !id_packet.uncond_branch
		|=> icache_addr == $past(icache_addr) + 32'd4)
		else begin
			error_count++;
			$error("ERR %0t: next fetch is not pc + 4", $time);
		end

	assert property (@(posedge clock) disable iff (reset)
		!id_packet.valid && !redirect |=> $stable(icache_addr))
		else begin
			error_count++;
			$error("ERR %0t: stalled fetch address moved", $time);
		end

	assert property (@(posedge clock) disable iff (reset)
		(!icache_valid || rob_full || rs_full[exp_fu]) |-> !id_packet.valid)
		else begin
			error_count++;
			$error("ERR %0t: packet valid without cache data or while full", $time);
		end

	assert property (@(posedge clock) disable iff (reset) redirect |-> !id_packet.valid)
		else begin
			error_count++;
			$error("ERR %0t: packet valid during redirect", $time);
		end

	assert property (@(posedge clock) disable iff (reset)
		redirect |=> icache_addr == $past(result.target_pc))
		else begin
			error_count++;
			$error("ERR %0t: redirect target not fetched", $time);
		end

	////////////////////////////////////////
	// decode fields and trained prediction
	////////////////////////////////////////
	assert property (@(posedge clock) disable iff (reset)
		id_packet.opa_areg_idx == icache_data[19:15] &&
		id_packet.opb_areg_idx == icache_data[24:20] && id_packet.dest_areg_idx == exp_dest)
		else begin
			error_count++;
			$error("ERR %0t: wrong register index", $time);
		end

	assert property (@(posedge clock) disable iff (reset)
		(opcode == opc_load || opcode == opc_store) |-> id_packet.fu_type == fu_mem)
		else begin
			error_count++;
			$error("ERR %0t: load/store not in mem class", $time);
		end

	assert property (@(posedge clock) disable iff (reset)
		trained && id_packet.valid && id_packet.pc == trained_pc
		|-> id_packet.branch_prediction && id_packet.npc == trained_target)
		else begin
			error_count++;
			$error("ERR %0t: trained branch not predicted", $time);
		end

endmodule

bind fetch_decode_top fetch_decode_assert checks (.*);

`default_nettype wire

/* dv/tb_fetch_decode.sv */
/*
 * Testbench for the fetch/decode front end: clock, reset, instruction
 * memory model, random stalls, branch resolutions and the verdict
 */
`default_nettype none
`timescale 1ns/1ps

module tb_fetch_decode;
	import isa_pkg::*;
	import frontend_pkg::*;

	logic        clock;
	logic        reset;
	logic        rob_full;
	logic [3:0]  rs_full;
	inst_t       icache_data;
	logic        icache_valid;
	result_t     result;
	logic [31:0] icache_addr;
	id_packet_t  id_packet;
	logic [31:0] program_rom [16];
	integer      seed;

	fetch_decode_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;           // 20 ns period
	end

	// combinational cache, nop past the program
	always_comb begin
		if (icache_addr < 32'd44)
			icache_data = program_rom[icache_addr[5:2]];
		else
			icache_data = 32'h0000_0013;
	end

	function automatic logic chance(input int percent);
		return ({$random(seed)} % 100) < percent;
	endfunction

	task automatic abort_run(input string why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	task automatic play_resolution(input logic [31:0] br_pc, input logic [31:0] target,
			input logic cond, input logic taken, input logic local_pred, input logic mis_pred);
		@(posedge clock);
		#2;
		result               = '0;
		result.valid         = 1'b1;
		result.pc            = br_pc;
		result.target_pc     = target;
		result.cond_branch   = cond;
		result.uncond_branch = !cond;
		result.taken         = taken;
		result.local_taken   = local_pred;     // global side still weak not-taken
		result.mis_pred      = mis_pred;
		@(posedge clock);
		#2;
		result = '0;
	endtask

	task automatic wait_for_fetch(input logic [31:0] addr, input int count, input int limit);
		int seen;
		int cycles;
		seen   = 0;
		cycles = 0;
		while (seen < count) begin
			@(negedge clock);
			if (id_packet.valid && id_packet.pc == addr)
				seen++;
			cycles++;
			if (cycles > limit)
				abort_run($sformatf("no valid fetch at %h within %0d cycles", addr, limit));
		end
	endtask

	// random back-pressure, one process owns these inputs
	initial begin
		icache_valid = 1'b0;
		rob_full     = 1'b0;
		rs_full      = '0;
		forever begin
			@(posedge clock);
			#2;
			icache_valid = chance(80);
			rob_full     = chance(10);
			rs_full      = {chance(10), chance(10), chance(10), chance(10)};
		end
	end

	always @(DUT.checks.error_count) begin
		if (DUT.checks.error_count != 0)
			abort_run("an assertion on the front end failed");
	end

	initial begin
		seed   = 19;
		reset  = 1'b1;
		result = '0;
		program_rom[0]  = 32'h0050_0093;      // addi x1, x0, 5
		program_rom[1]  = 32'h0070_0113;      // addi x2, x0, 7
		program_rom[2]  = 32'h0020_81B3;      // add  x3, x1, x2
		program_rom[3]  = 32'h4011_8233;      // sub  x4, x3, x1
		program_rom[4]  = 32'h0000_A283;      // lw   x5, 0(x1)
		program_rom[5]  = 32'h0051_2223;      // sw   x5, 4(x2)
		program_rom[6]  = 32'h0220_8333;      // mul  x6, x1, x2
		program_rom[7]  = 32'h0041_C3B3;      // xor  x7, x3, x4
		program_rom[8]  = 32'hFE20_84E3;      // beq  x1, x2, 0x08
		program_rom[9]  = 32'h0020_E433;      // or   x8, x1, x2
		program_rom[10] = 32'hFD9F_F0EF;      // jal  x1, 0x00
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		// one taken outcome, loop 0x08..0x20 should then be predicted
		play_resolution(32'h20, 32'h08, 1'b1, 1'b1, 1'b0, 1'b0);
		wait_for_fetch(32'h20, 4, 400);
		// mispredicted fall-through sends fetch on to the jal
		play_resolution(32'h20, 32'h24, 1'b1, 1'b0, 1'b1, 1'b1);
		wait_for_fetch(32'h28, 1, 400);
		play_resolution(32'h28, 32'h00, 1'b0, 1'b1, 1'b0, 1'b1);
		wait_for_fetch(32'h28, 3, 800);      // jal now a btb hit
		if (DUT.checks.error_count == 0) begin
			$display("Test passed");
			$finish;
		end else
			abort_run("assertion failures were counted");
	end

endmodule

`default_nettype wire

/* tb.f */
source/isa_pkg.sv
source/frontend_pkg.sv
source/inst_decoder.sv
source/branch_target_buffer.sv
source/branch_predictor.sv
source/fetch_control.sv
source/fetch_decode_top.sv
dv/fetch_decode_assert.sv
dv/tb_fetch_decode.sv

/* Makefile */
# Verilator simulation of the fetch/decode front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_decode
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
